// ==== Makefile ====
TOP := tb_test_master

.PHONY: all build lint clean

all: build
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	  echo "$$out" | grep -qx 'STATUS: PASS'

build:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f files.f

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f files.f

clean:
	rm -rf obj_dir

// ==== files.f ====
source/cache_test_pkg.sv
source/trace_rom.sv
source/trace_replay.sv
source/data_cache.sv
source/test_master.sv
verif/tb_clock_gen.sv
verif/test_master_properties.sv
verif/tb_test_master.sv

// ==== source/cache_test_pkg.sv ====
package cache_test_pkg;

  localparam int OP_WIDTH         = 2;
  localparam int IDX_WIDTH        = 6;  // rom index, wide enough to run past the program.
  localparam int ENTRY_ADDR_WIDTH = 6;  // the program lives in a 64-word space.
  localparam int ENTRY_DATA_WIDTH = 32;
  localparam int TRACE_LEN        = 40;
  localparam int STORE_COUNT      = 16;

  localparam logic [ENTRY_DATA_WIDTH-1:0] STORE_BASE = 32'h5a00_0000;

  typedef enum logic [OP_WIDTH-1:0] {
    OP_LOAD  = 2'd0,
    OP_STORE = 2'd1,
    OP_DONE  = 2'd2
  } op_e;

  typedef enum logic {
    DMA_FILL  = 1'b0,  // read one whole block.
    DMA_WRITE = 1'b1   // write a single word.
  } dma_cmd_e;

  typedef struct packed {
    op_e                         op;
    logic [ENTRY_ADDR_WIDTH-1:0] addr;
    logic [ENTRY_DATA_WIDTH-1:0] data;
  } trace_entry_t;

  // word address written by store number j.
  function automatic logic [ENTRY_ADDR_WIDTH-1:0] store_addr(input int unsigned j);
    return ENTRY_ADDR_WIDTH'((3 * j) % (2 ** ENTRY_ADDR_WIDTH));
  endfunction

  function automatic logic [ENTRY_DATA_WIDTH-1:0] store_data(input int unsigned j);
    return STORE_BASE + ENTRY_DATA_WIDTH'(j);
  endfunction

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // the trace program, one entry per index.
  function automatic trace_entry_t trace_entry(input int unsigned k);
    trace_entry_t e;
    int unsigned  j;
    e.op   = OP_DONE;
    e.addr = '0;
    e.data = '0;
    if (k < STORE_COUNT) begin
      e.op   = OP_STORE;
      e.addr = store_addr(k);
      e.data = store_data(k);
    end else if (k < 2 * STORE_COUNT) begin
      j      = 2 * STORE_COUNT - 1 - k;  // replay the stores backwards.
      e.op   = OP_LOAD;
      e.addr = store_addr(j);
      e.data = store_data(j);
    end else if (k < TRACE_LEN - 1) begin
      e.op   = OP_LOAD;
      e.addr = ENTRY_ADDR_WIDTH'(k - 2 * STORE_COUNT);
      for (j = 0; j < STORE_COUNT; j++) begin
        if (store_addr(j) == e.addr) e.data = store_data(j);  // the last writer wins.
      end
    end
    return e;
  endfunction

endpackage

// ==== source/data_cache.sv ====
module data_cache #(
  parameter int ADDR_WIDTH = 12
  , parameter int DATA_WIDTH = 32
  , parameter int SETS = 4
  , parameter int BLOCK_WORDS = 4
) (
  input  logic                      clk_i
  , input  logic                    rst_n_i

  , input  logic                    cmd_v_i
  , input  cache_test_pkg::op_e     cmd_op_i
  , input  logic [ADDR_WIDTH-1:0]   cmd_addr_i
  , input  logic [DATA_WIDTH-1:0]   cmd_data_i
  , output logic                    cmd_ready_o

  , output logic                    resp_v_o
  , output logic [DATA_WIDTH-1:0]   resp_data_o
  , input  logic                    resp_yumi_i

  , output logic                    dma_pkt_v_o
  , output cache_test_pkg::dma_cmd_e dma_pkt_cmd_o
  , output logic [ADDR_WIDTH-1:0]   dma_pkt_addr_o
  , input  logic                    dma_pkt_yumi_i

  , input  logic [DATA_WIDTH-1:0]   dma_data_i
  , input  logic                    dma_data_v_i
  , output logic                    dma_data_ready_o

  , output logic [DATA_WIDTH-1:0]   dma_data_o
  , output logic                    dma_data_v_o
  , input  logic                    dma_data_yumi_i
);

  localparam int OFFSET_W = $clog2(BLOCK_WORDS);
  localparam int INDEX_W  = $clog2(SETS);
  localparam int TAG_W    = ADDR_WIDTH - INDEX_W - OFFSET_W;

  typedef enum logic [2:0] {
    C_IDLE,
    C_LOOKUP,
    C_FILL_REQ,
    C_FILL,
    C_WR_REQ,
    C_WR_DATA,
    C_RESP
  } state_e;

  state_e state_r, state_n;

  logic [TAG_W-1:0]      tag_mem  [SETS];
  logic [SETS-1:0]       valid_r;
  logic [DATA_WIDTH-1:0] data_mem [SETS*BLOCK_WORDS];

  logic [ADDR_WIDTH-1:0] addr_r;
  logic [DATA_WIDTH-1:0] wdata_r;
  cache_test_pkg::op_e   op_r;
  logic [OFFSET_W-1:0]   beat_r;
  logic [DATA_WIDTH-1:0] resp_data_r;

  logic [TAG_W-1:0]      tag;
  logic [INDEX_W-1:0]    index;
  logic [OFFSET_W-1:0]   offset;
  logic                  hit;
  logic                  is_load;
  logic                  accept;
  logic                  fill_beat;
  logic                  last_beat;
  logic [DATA_WIDTH-1:0] hit_data;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // address split and lookup

  assign {tag, index, offset} = addr_r;

  assign hit       = valid_r[index] && (tag_mem[index] == tag);
  assign is_load   = (op_r == cache_test_pkg::OP_LOAD);
  assign hit_data  = data_mem[{index, offset}];
  assign accept    = cmd_v_i && cmd_ready_o;
  assign fill_beat = (state_r == C_FILL) && dma_data_v_i;
  assign last_beat = (beat_r == OFFSET_W'(BLOCK_WORDS - 1));

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // outputs, all decoded from registered state

  assign cmd_ready_o = (state_r == C_IDLE);

  // a load hit answers straight out of the lookup cycle.
  assign resp_v_o    = (state_r == C_RESP) || ((state_r == C_LOOKUP) && is_load && hit);
  assign resp_data_o = (state_r == C_LOOKUP) ? hit_data : resp_data_r;

  assign dma_pkt_v_o    = (state_r == C_FILL_REQ) || (state_r == C_WR_REQ);
  assign dma_pkt_cmd_o  = (state_r == C_WR_REQ) ? cache_test_pkg::DMA_WRITE
                                                : cache_test_pkg::DMA_FILL;
  assign dma_pkt_addr_o = (state_r == C_WR_REQ) ? addr_r : {tag, index, {OFFSET_W{1'b0}}};

  assign dma_data_ready_o = (state_r == C_FILL);
  assign dma_data_v_o     = (state_r == C_WR_DATA);
  assign dma_data_o       = wdata_r;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // state machine

  always_comb begin
    state_n = state_r;
    case (state_r)
      C_IDLE: begin
        if (cmd_v_i) state_n = C_LOOKUP;
      end
      C_LOOKUP: begin
        if (!is_load) begin
          state_n = C_WR_REQ;  // write-through, hit or not.
        end else if (!hit) begin
          state_n = C_FILL_REQ;
        end else if (resp_yumi_i) begin
          state_n = C_IDLE;
        end else begin
          state_n = C_RESP;
        end
      end
      C_FILL_REQ: begin
        if (dma_pkt_yumi_i) state_n = C_FILL;
      end
      C_FILL: begin
        if (fill_beat && last_beat) state_n = C_RESP;
      end
      C_WR_REQ: begin
        if (dma_pkt_yumi_i) state_n = C_WR_DATA;
      end
      C_WR_DATA: begin
        if (dma_data_yumi_i) state_n = C_RESP;
      end
      C_RESP: begin
        if (resp_yumi_i) state_n = C_IDLE;
      end
      default: state_n = C_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_r <= C_IDLE;
      valid_r <= '0;
      beat_r  <= '0;
    end else begin
      state_r <= state_n;
      if ((state_r == C_FILL_REQ) && dma_pkt_yumi_i) beat_r <= '0;
      if (fill_beat) begin
        beat_r <= beat_r + 1'b1;
        if (last_beat) valid_r[index] <= 1'b1;  // line is usable once complete.
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // arrays and command registers

  always_ff @(posedge clk_i) begin
    if (accept) begin
      addr_r  <= cmd_addr_i;
      wdata_r <= cmd_data_i;
      op_r    <= cmd_op_i;
    end

    if (state_r == C_LOOKUP) begin
      resp_data_r <= hit_data;  // held in case the hit response is not taken.
      if (!is_load && hit) data_mem[{index, offset}] <= wdata_r;
    end

    if (fill_beat) begin
      data_mem[{index, beat_r}] <= dma_data_i;
      if (beat_r == offset) resp_data_r <= dma_data_i;  // the word that missed.
      if (last_beat) tag_mem[index] <= tag;
    end
  end

endmodule

// ==== source/test_master.sv ====
module test_master #(
  parameter int ADDR_WIDTH = 12
  , parameter int DATA_WIDTH = 32
  , parameter int SETS = 4
  , parameter int BLOCK_WORDS = 4
) (
  input  logic                       clk_i
  , input  logic                     rst_n_i

  , output logic                     dma_pkt_v_o
  , output cache_test_pkg::dma_cmd_e dma_pkt_cmd_o
  , output logic [ADDR_WIDTH-1:0]    dma_pkt_addr_o
  , input  logic                     dma_pkt_yumi_i

  , input  logic [DATA_WIDTH-1:0]    dma_data_i
  , input  logic                     dma_data_v_i
  , output logic                     dma_data_ready_o

  , output logic [DATA_WIDTH-1:0]    dma_data_o
  , output logic                     dma_data_v_o
  , input  logic                     dma_data_yumi_i

  , output logic                     done_o
  , output logic                     error_o
);

  // rom to replay.
  logic [cache_test_pkg::IDX_WIDTH-1:0] rom_addr;
  cache_test_pkg::op_e                  rom_op;
  logic [ADDR_WIDTH-1:0]                rom_entry_addr;
  logic [DATA_WIDTH-1:0]                rom_entry_data;

  // replay to cache and back.
  logic                  cmd_v;
  cache_test_pkg::op_e   cmd_op;
  logic [ADDR_WIDTH-1:0] cmd_addr;
  logic [DATA_WIDTH-1:0] cmd_data;
  logic                  cmd_ready;
  logic                  resp_v;
  logic [DATA_WIDTH-1:0] resp_data;
  logic                  resp_yumi;

  trace_rom #(
    .ADDR_WIDTH(ADDR_WIDTH)
    , .DATA_WIDTH(DATA_WIDTH)
  ) rom_i (
    .rom_addr_i(rom_addr)
    , .rom_op_o(rom_op)
    , .rom_addr_o(rom_entry_addr)
    , .rom_data_o(rom_entry_data)
  );

  trace_replay #(
    .ADDR_WIDTH(ADDR_WIDTH)
    , .DATA_WIDTH(DATA_WIDTH)
  ) replay_i (
    .clk_i(clk_i)
    , .rst_n_i(rst_n_i)
    , .rom_addr_o(rom_addr)
    , .rom_op_i(rom_op)
    , .rom_addr_i(rom_entry_addr)
    , .rom_data_i(rom_entry_data)
    , .cmd_v_o(cmd_v)
    , .cmd_op_o(cmd_op)
    , .cmd_addr_o(cmd_addr)
    , .cmd_data_o(cmd_data)
    , .cmd_ready_i(cmd_ready)
    , .resp_v_i(resp_v)
    , .resp_data_i(resp_data)
    , .resp_yumi_o(resp_yumi)
    , .done_o(done_o)
    , .error_o(error_o)
  );

  data_cache #(
    .ADDR_WIDTH(ADDR_WIDTH)
    , .DATA_WIDTH(DATA_WIDTH)
    , .SETS(SETS)
    , .BLOCK_WORDS(BLOCK_WORDS)
  ) cache_i (
    .clk_i(clk_i)
    , .rst_n_i(rst_n_i)
    , .cmd_v_i(cmd_v)
    , .cmd_op_i(cmd_op)
    , .cmd_addr_i(cmd_addr)
    , .cmd_data_i(cmd_data)
    , .cmd_ready_o(cmd_ready)
    , .resp_v_o(resp_v)
    , .resp_data_o(resp_data)
    , .resp_yumi_i(resp_yumi)
    , .dma_pkt_v_o(dma_pkt_v_o)
    , .dma_pkt_cmd_o(dma_pkt_cmd_o)
    , .dma_pkt_addr_o(dma_pkt_addr_o)
    , .dma_pkt_yumi_i(dma_pkt_yumi_i)
    , .dma_data_i(dma_data_i)
    , .dma_data_v_i(dma_data_v_i)
    , .dma_data_ready_o(dma_data_ready_o)
    , .dma_data_o(dma_data_o)
    , .dma_data_v_o(dma_data_v_o)
    , .dma_data_yumi_i(dma_data_yumi_i)
  );

endmodule

// ==== source/trace_replay.sv ====
module trace_replay #(
  parameter int ADDR_WIDTH = 12
  , parameter int DATA_WIDTH = 32
) (
  input  logic                                 clk_i
  , input  logic                               rst_n_i

  , output logic [cache_test_pkg::IDX_WIDTH-1:0] rom_addr_o
  , input  cache_test_pkg::op_e                rom_op_i
  , input  logic [ADDR_WIDTH-1:0]              rom_addr_i
  , input  logic [DATA_WIDTH-1:0]              rom_data_i

  , output logic                               cmd_v_o
  , output cache_test_pkg::op_e                cmd_op_o
  , output logic [ADDR_WIDTH-1:0]              cmd_addr_o
  , output logic [DATA_WIDTH-1:0]              cmd_data_o
  , input  logic                               cmd_ready_i

  , input  logic                               resp_v_i
  , input  logic [DATA_WIDTH-1:0]              resp_data_i
  , output logic                               resp_yumi_o

  , output logic                               done_o
  , output logic                               error_o
);

  typedef enum logic [1:0] {
    S_FETCH,
    S_SEND,
    S_WAIT,
    S_DONE
  } state_e;

  state_e state_r, state_n;

  logic [cache_test_pkg::IDX_WIDTH-1:0] idx_r;
  logic [cache_test_pkg::IDX_WIDTH-1:0] idx_n;
  logic [DATA_WIDTH-1:0]                exp_r;
  logic                                 load_r;
  logic                                 error_r;
  logic                                 consume;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // index and rom lookahead

  assign consume     = (state_r == S_WAIT) && resp_v_i;
  assign resp_yumi_o = consume;

  // while a response is consumed the rom already shows the next entry,
  // so the next command can leave in the following cycle.
  assign idx_n      = consume ? idx_r + 1'b1 : idx_r;
  assign rom_addr_o = idx_n;

  assign cmd_v_o    = (state_r == S_SEND);
  assign cmd_op_o   = rom_op_i;
  assign cmd_addr_o = rom_addr_i;
  assign cmd_data_o = rom_data_i;  // for a load this is the expected value.

  assign done_o  = (state_r == S_DONE);
  assign error_o = error_r;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // state machine

  always_comb begin
    state_n = state_r;
    case (state_r)
      S_FETCH: begin
        state_n = (rom_op_i == cache_test_pkg::OP_DONE) ? S_DONE : S_SEND;
      end
      S_SEND: begin
        if (cmd_ready_i) state_n = S_WAIT;
      end
      S_WAIT: begin
        if (resp_v_i) begin
          state_n = (rom_op_i == cache_test_pkg::OP_DONE) ? S_DONE : S_SEND;
        end
      end
      default: state_n = S_DONE;  // stays here until reset.
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_r <= S_FETCH;
      idx_r   <= '0;
      error_r <= 1'b0;
    end else begin
      state_r <= state_n;
      idx_r   <= idx_n;
      if (consume && load_r && (resp_data_i != exp_r)) begin
        error_r <= 1'b1;  // sticky.
      end
    end
  end

  // capture what the response will be checked against.
  always_ff @(posedge clk_i) begin
    if (cmd_v_o && cmd_ready_i) begin
      exp_r  <= rom_data_i;
      load_r <= (rom_op_i == cache_test_pkg::OP_LOAD);
    end
  end

endmodule

// ==== source/trace_rom.sv ====
module trace_rom #(
  parameter int ADDR_WIDTH = 12
  , parameter int DATA_WIDTH = 32
) (
  input  logic [cache_test_pkg::IDX_WIDTH-1:0] rom_addr_i
  , output cache_test_pkg::op_e                rom_op_o
  , output logic [ADDR_WIDTH-1:0]              rom_addr_o
  , output logic [DATA_WIDTH-1:0]              rom_data_o
);

  cache_test_pkg::trace_entry_t entry;

  always_comb begin
    entry = cache_test_pkg::trace_entry(rom_addr_i);

    // anything beyond the program reads as the end marker.
    if (rom_addr_i < cache_test_pkg::TRACE_LEN) begin
      rom_op_o = entry.op;
    end else begin
      rom_op_o = cache_test_pkg::OP_DONE;
    end

    rom_addr_o = ADDR_WIDTH'(entry.addr);  // program space sits at the bottom.
    rom_data_o = DATA_WIDTH'(entry.data);
  end

endmodule

// ==== verif/tb_clock_gen.sv ====
module tb_clock_gen #(
  parameter int RESET_CYCLES = 10
) (
  input  logic   reset_req_i
  , output logic clk_o
  , output logic rst_n_o
);

  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk_o = 1'b0;
    forever #10 clk_o = ~clk_o;  // 20 ns period.
  end

  // reset is low from time zero and again after every request.
  initial begin
    rst_n_o = 1'b0;
    forever begin
      repeat (RESET_CYCLES) @(posedge clk_o);
      @(negedge clk_o);
      rst_n_o = 1'b1;
      @(posedge reset_req_i);
      @(negedge clk_o);
      rst_n_o = 1'b0;
    end
  end

endmodule

// ==== verif/tb_test_master.sv ====
module tb_test_master;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int ADDR_WIDTH  = 12;
  localparam int DATA_WIDTH  = 32;
  localparam int SETS        = 4;
  localparam int BLOCK_WORDS = 4;
  localparam int MEM_WORDS   = 64;
  localparam int STORES      = 16;
  localparam int WAIT_LIMIT  = 200;
  localparam int RUN_LIMIT   = 20000;
  localparam logic [31:0] SEED       = 32'hec80aef4;
  localparam logic [31:0] PATCH_WORD = 32'hbad0_c0de;

  logic                     clk;
  logic                     rst_n;
  logic                     reset_req;
  logic                     pkt_v;
  cache_test_pkg::dma_cmd_e pkt_cmd;
  logic [ADDR_WIDTH-1:0]    pkt_addr;
  logic                     pkt_yumi;
  logic [DATA_WIDTH-1:0]    fill_data;
  logic                     fill_v;
  logic                     fill_ready;
  logic [DATA_WIDTH-1:0]    wr_data;
  logic                     wr_v;
  logic                     wr_yumi;
  logic                     done;
  logic                     error;

  logic [DATA_WIDTH-1:0] mem [MEM_WORDS];
  int unsigned           patch_addr;
  int                    errors;
  int                    timeouts;
  int                    writes_seen;
  int                    wdata_seen;
  int                    fills_seen;
  int                    beats;
  bit                    error_seen;

  tb_clock_gen clock_i (.reset_req_i(reset_req), .clk_o(clk), .rst_n_o(rst_n));

  test_master #(
    .ADDR_WIDTH(ADDR_WIDTH)
    , .DATA_WIDTH(DATA_WIDTH)
    , .SETS(SETS)
    , .BLOCK_WORDS(BLOCK_WORDS)
  ) dut_i (
    .clk_i(clk)
    , .rst_n_i(rst_n)
    , .dma_pkt_v_o(pkt_v)
    , .dma_pkt_cmd_o(pkt_cmd)
    , .dma_pkt_addr_o(pkt_addr)
    , .dma_pkt_yumi_i(pkt_yumi)
    , .dma_data_i(fill_data)
    , .dma_data_v_i(fill_v)
    , .dma_data_ready_o(fill_ready)
    , .dma_data_o(wr_data)
    , .dma_data_v_o(wr_v)
    , .dma_data_yumi_i(wr_yumi)
    , .done_o(done)
    , .error_o(error)
  );

  bind test_master test_master_properties #(
    .ADDR_WIDTH(ADDR_WIDTH)
    , .DATA_WIDTH(DATA_WIDTH)
  ) props_i (
    .clk_i(clk_i)
    , .rst_n_i(rst_n_i)
    , .pkt_v_i(dma_pkt_v_o)
    , .pkt_cmd_i(dma_pkt_cmd_o)
    , .pkt_addr_i(dma_pkt_addr_o)
    , .pkt_yumi_i(dma_pkt_yumi_i)
    , .wr_data_i(dma_data_o)
    , .wr_v_i(dma_data_v_o)
    , .wr_yumi_i(dma_data_yumi_i)
    , .done_i(done_o)
    , .error_i(error_o)
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // reference model of the trace program

  function automatic logic [ADDR_WIDTH-1:0] store_addr_ref(input int unsigned j);
    return ADDR_WIDTH'((3 * j) % MEM_WORDS);
  endfunction

  function automatic logic [DATA_WIDTH-1:0] store_data_ref(input int unsigned j);
    return 32'h5a00_0000 + DATA_WIDTH'(j);
  endfunction

  // one word of the image after all stores hit a zeroed memory.
  function automatic logic [DATA_WIDTH-1:0] expected_mem(input int unsigned addr);
    logic [DATA_WIDTH-1:0] word;
    int unsigned           j;
    word = '0;
    for (j = 0; j < STORES; j++) begin
      if (store_addr_ref(j) == ADDR_WIDTH'(addr)) word = store_data_ref(j);
    end
    return word;
  endfunction

  // the trailing loads read words 0 to 6; pick one that no store wrote.
  function automatic int unsigned pick_patch_addr();
    int unsigned cand [$];
    int unsigned a;
    for (a = 0; a < 7; a++) begin
      if (expected_mem(a) == '0) cand.push_back(a);
    end
    return cand[$urandom_range(cand.size() - 1)];
  endfunction

  task automatic check_value(input string what, input logic [DATA_WIDTH-1:0] got,
                             input logic [DATA_WIDTH-1:0] exp);
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic report_timeout(input string what);
    timeouts++;
    $display("timeout at %0t ns: %s", $time, what);
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // compare process on the DMA port

  always @(posedge clk) begin
    if (!rst_n) begin
      writes_seen = 0;
      wdata_seen  = 0;
      fills_seen  = 0;
      beats       = 0;
      error_seen  = 1'b0;
    end else begin
      if (pkt_v && pkt_yumi) begin
        $display("%0t ns: DMA %s packet at word %0d", $time, pkt_cmd.name(), pkt_addr);
        if (pkt_cmd == cache_test_pkg::DMA_WRITE) begin
          if (writes_seen < STORES) check_value("write address", pkt_addr,
                                                store_addr_ref(writes_seen));
          writes_seen++;
        end else begin
          check_value("fill alignment", pkt_addr % BLOCK_WORDS, 0);
          check_value("fill inside 64 words", pkt_addr < MEM_WORDS, 1);
          fills_seen++;
          beats = 0;
        end
      end
      // the cache takes exactly one block per fill and nothing in between.
      if (fill_ready) begin
        check_value("fill ready outside a fill", (fills_seen > 0) && (beats < BLOCK_WORDS), 1);
      end
      if (fill_v && fill_ready) beats++;
      if (wr_v && wr_yumi) begin
        if (wdata_seen < STORES) check_value("write data", wr_data, store_data_ref(wdata_seen));
        wdata_seen++;
      end
      if (error_seen) check_value("error flag held", error, 1'b1);
      if (error) error_seen = 1'b1;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // memory model driven on the falling edge

  task automatic serve_fill(input logic [ADDR_WIDTH-1:0] base, output bit ok);
    int unsigned beat;
    int unsigned waited;
    logic        ready_seen;
    beat       = 0;
    waited     = 0;
    ready_seen = 1'b0;
    ok         = 1'b1;
    while (beat < BLOCK_WORDS && ok) begin
      if (fill_v && ready_seen) begin  // taken at the last rising edge.
        beat++;
        fill_v = 1'b0;
      end
      if (beat < BLOCK_WORDS && !fill_v && ($urandom_range(3) != 0)) begin
        fill_v    = 1'b1;
        fill_data = mem[(base + beat) % MEM_WORDS];
      end
      ready_seen = fill_ready;
      if (beat < BLOCK_WORDS) begin
        @(negedge clk);
        waited++;
        if (waited > WAIT_LIMIT) begin
          report_timeout("fill beats were not taken");
          ok = 1'b0;
        end
      end
    end
    fill_v = 1'b0;
  endtask

  task automatic serve_write(input logic [ADDR_WIDTH-1:0] addr, output bit ok);
    int unsigned waited;
    waited = 0;
    ok     = 1'b1;
    while (!(wr_v && ($urandom_range(3) != 0)) && ok) begin
      @(negedge clk);
      waited++;
      if (waited > WAIT_LIMIT) begin
        report_timeout("store word never arrived");
        ok = 1'b0;
      end
    end
    if (ok) begin
      wr_yumi = 1'b1;
      mem[addr % MEM_WORDS] = wr_data;
      @(negedge clk);
      wr_yumi = 1'b0;
    end
  endtask

  task automatic take_packet(output bit ok);
    cache_test_pkg::dma_cmd_e cmd;
    logic [ADDR_WIDTH-1:0]    addr;
    cmd      = pkt_cmd;
    addr     = pkt_addr;
    pkt_yumi = 1'b1;  // valid is stable until the next rising edge.
    @(negedge clk);
    pkt_yumi = 1'b0;
    if (cmd == cache_test_pkg::DMA_FILL) serve_fill(addr, ok);
    else serve_write(addr, ok);
  endtask

  task automatic run_program(output bit ok);
    int unsigned cycles;
    cycles = 0;
    ok     = 1'b1;
    while (!done && ok) begin
      @(negedge clk);
      cycles++;
      if (cycles > RUN_LIMIT) begin
        report_timeout("done never rose");
        ok = 1'b0;
      end else if (pkt_v && ($urandom_range(3) != 0)) begin
        take_packet(ok);
      end
    end
  endtask

  task automatic wait_reset_level(input logic level, output bit ok);
    int unsigned waited;
    waited = 0;
    ok     = 1'b1;
    while (rst_n !== level && ok) begin
      @(negedge clk);
      waited++;
      if (waited > WAIT_LIMIT) begin
        report_timeout("reset did not change");
        ok = 1'b0;
      end
    end
  endtask

  task automatic check_run(input bit patched);
    int unsigned           a;
    logic [DATA_WIDTH-1:0] want;
    check_value("error flag at done", error, patched);
    check_value("DMA write packets", writes_seen, STORES);
    check_value("store words", wdata_seen, STORES);
    for (a = 0; a < MEM_WORDS; a++) begin
      want = (patched && a == patch_addr) ? PATCH_WORD : expected_mem(a);
      check_value($sformatf("memory word %0d", a), mem[a], want);
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // two runs; the second one reads a word the program never wrote.

  initial begin
    bit ok;
    int run;
    void'($urandom(SEED));
    reset_req = 1'b0;
    pkt_yumi  = 1'b0;
    fill_data = '0;
    fill_v    = 1'b0;
    wr_yumi   = 1'b0;
    errors    = 0;
    timeouts  = 0;
    ok        = 1'b1;
    for (int unsigned a = 0; a < MEM_WORDS; a++) mem[a] = '0;

    for (run = 0; run < 2 && ok; run++) begin
      if (run == 1) begin
        patch_addr = pick_patch_addr();
        for (int unsigned a = 0; a < MEM_WORDS; a++) mem[a] = '0;
        mem[patch_addr] = PATCH_WORD;
        $display("second run with word %0d patched", patch_addr);
        reset_req = 1'b1;
        wait_reset_level(1'b0, ok);
        reset_req = 1'b0;
      end
      if (ok) wait_reset_level(1'b1, ok);
      if (ok) run_program(ok);
      if (ok) check_run(run == 1);
    end

    $display("errors: %0d failed checks, %0d timeouts", errors, timeouts);
    if (ok && errors == 0 && timeouts == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

// ==== verif/test_master_properties.sv ====
module test_master_properties #(
  parameter int ADDR_WIDTH = 12
  , parameter int DATA_WIDTH = 32
) (
  input  logic                       clk_i
  , input  logic                     rst_n_i
  , input  logic                     pkt_v_i
  , input  cache_test_pkg::dma_cmd_e pkt_cmd_i
  , input  logic [ADDR_WIDTH-1:0]    pkt_addr_i
  , input  logic                     pkt_yumi_i
  , input  logic [DATA_WIDTH-1:0]    wr_data_i
  , input  logic                     wr_v_i
  , input  logic                     wr_yumi_i
  , input  logic                     done_i
  , input  logic                     error_i
);

  timeunit 1ns;
  timeprecision 100ps;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // DMA handshakes

  pkt_hold_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    pkt_v_i && !pkt_yumi_i |=> pkt_v_i && $stable(pkt_cmd_i) && $stable(pkt_addr_i))
    else $error("DMA packet dropped or changed before yumi");

  wr_hold_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    wr_v_i && !wr_yumi_i |=> wr_v_i && $stable(wr_data_i))
    else $error("store word dropped or changed before yumi");

  // the store word follows straight after its accepted write packet.
  wr_after_pkt_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $rose(wr_v_i) |-> $past(pkt_v_i && pkt_yumi_i && (pkt_cmd_i == cache_test_pkg::DMA_WRITE)))
    else $error("store word raised without an accepted DMA write packet");

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // status flags hold until reset

  done_sticky_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    done_i |=> done_i)
    else $error("done fell before reset");

  error_sticky_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    error_i |=> error_i)
    else $error("error flag cleared before reset");

endmodule
